/* hdl/fm_timer_pkg.sv */
// Register numbers, busy states, timer config and flag structs, timer widths
`default_nettype none

package fm_timer_pkg;

    // Timer register numbers written at address 0
    typedef enum logic [7:0] {
        REG_TMRA_HI = 8'h24,    // Timer A bits 9..2
        REG_TMRA_LO = 8'h25,    // Timer A bits 1..0
        REG_TMRB    = 8'h26,
        REG_TMR_CTL = 8'h27
    } reg_addr_e;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } busy_state_e;

    localparam int TMRA_W      = 10;
    localparam int TMRB_W      = 8;
    localparam int TMRB_SUBDIV = 16;   // Timer A ticks per timer B tick

    // Bit positions in REG_TMR_CTL
    localparam int CTL_LOAD_A  = 0;
    localparam int CTL_LOAD_B  = 1;
    localparam int CTL_IRQEN_A = 2;
    localparam int CTL_IRQEN_B = 3;
    localparam int CTL_CLR_A   = 4;
    localparam int CTL_CLR_B   = 5;

    typedef struct packed {
        logic [TMRA_W-1:0] value_a;
        logic [TMRB_W-1:0] value_b;
        logic              load_a;
        logic              load_b;
        logic              irq_en_a;
        logic              irq_en_b;
    } tmr_cfg_t;

    typedef struct packed {
        logic a;
        logic b;
    } flag_pulse_t;

endpackage

`default_nettype wire

/* hdl/fm_timer_counter.sv */
// Loadable up-counter with reload and overflow pulse
`default_nettype none

module fm_timer_counter #(
    parameter int width = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic             load,
    input  logic [width-1:0] value,
    output logic             ovf
);

    logic [width-1:0] cnt;
    logic             at_top;

    assign at_top = &cnt;   // All ones, next tick wraps

    // Overflow period is 2^width - value ticks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            ovf <= 1'b0;
        end else begin
            ovf <= 1'b0;
            if (!load) begin
                cnt <= value;           // Parked at the load value
            end else if (tick) begin
                if (at_top) begin
                    cnt <= value;
                    ovf <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fm_reg_decode.sv */
// CPU write decode, timer registers, flag clear pulses and busy timing
`default_nettype none

module fm_reg_decode #(
    parameter int busy_cycles = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [7:0]             din,
    input  logic [1:0]             addr,
    input  logic                   cs_n,
    input  logic                   wr_n,
    output fm_timer_pkg::tmr_cfg_t    cfg,
    output fm_timer_pkg::flag_pulse_t clr,
    output logic                   busy
);
    import fm_timer_pkg::*;

    localparam int CNT_W = (busy_cycles > 1) ? $clog2(busy_cycles) : 1;

    logic        write;
    logic        data_wr;
    reg_addr_e   reg_num;      // Latched at address 0
    busy_state_e state;
    logic [CNT_W-1:0] busy_cnt;

    assign write   = !cs_n && !wr_n;
    assign data_wr = write && addr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_num <= reg_addr_e'(8'h00);
        end else if (write && !addr[0]) begin
            reg_num <= reg_addr_e'(din);
        end
    end

    // Timer registers, clear bits only live for one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
            clr <= '0;
        end else begin
            clr <= '0;
            if (data_wr) begin
                case (reg_num)
                    REG_TMRA_HI: cfg.value_a[TMRA_W-1:2] <= din;
                    REG_TMRA_LO: cfg.value_a[1:0] <= din[1:0];
                    REG_TMRB:    cfg.value_b <= din;
                    REG_TMR_CTL: begin
                        cfg.load_a   <= din[CTL_LOAD_A];
                        cfg.load_b   <= din[CTL_LOAD_B];
                        cfg.irq_en_a <= din[CTL_IRQEN_A];
                        cfg.irq_en_b <= din[CTL_IRQEN_B];
                        clr.a        <= din[CTL_CLR_A];
                        clr.b        <= din[CTL_CLR_B];
                    end
                    default: ;  // Unknown register, write dropped
                endcase
            end
        end
    end

    // Busy FSM, any data write (re)starts the count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            busy_cnt <= '0;
        end else if (data_wr) begin
            state    <= ST_BUSY;
            busy_cnt <= CNT_W'(busy_cycles - 1);
        end else if (state == ST_BUSY) begin
            if (busy_cnt == '0) begin
                state <= ST_IDLE;
            end else begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    assign busy = (state == ST_BUSY);

    // Busy must drop busy_cycles after the last data write
    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        data_wr ##1 (!data_wr)[*busy_cycles] |=> !busy);

endmodule

`default_nettype wire

/* hdl/fm_timer_exec.sv */
// Timer execute stage with cen prescaler, timer B sub-divider and both counters
`default_nettype none

module fm_timer_exec #(
    parameter int tick_div = 72
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen,
    input  fm_timer_pkg::tmr_cfg_t    cfg,
    output fm_timer_pkg::flag_pulse_t ovf
);
    import fm_timer_pkg::*;

    localparam int PRE_W = (tick_div > 1) ? $clog2(tick_div) : 1;
    localparam int SUB_W = $clog2(TMRB_SUBDIV);

    logic [PRE_W-1:0] pre_cnt;
    logic [SUB_W-1:0] sub_cnt;
    logic             tick_a;
    logic             tick_b;
    logic             ovf_a;
    logic             ovf_b;

    assign tick_a = cen && (pre_cnt == PRE_W'(tick_div - 1));
    assign tick_b = tick_a && (sub_cnt == SUB_W'(TMRB_SUBDIV - 1));

    // Free running, so the first period carries some phase slack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            sub_cnt <= '0;
        end else if (cen) begin
            pre_cnt <= tick_a ? '0 : pre_cnt + 1'b1;
            if (tick_a) begin
                sub_cnt <= tick_b ? '0 : sub_cnt + 1'b1;
            end
        end
    end

    fm_timer_counter #(.width(TMRA_W)) u_timer_a (
        .clk   ( clk         ),
        .rst_n ( rst_n       ),
        .tick  ( tick_a      ),
        .load  ( cfg.load_a  ),
        .value ( cfg.value_a ),
        .ovf   ( ovf_a       )
    );

    fm_timer_counter #(.width(TMRB_W)) u_timer_b (
        .clk   ( clk         ),
        .rst_n ( rst_n       ),
        .tick  ( tick_b      ),
        .load  ( cfg.load_b  ),
        .value ( cfg.value_b ),
        .ovf   ( ovf_b       )
    );

    assign ovf = '{a: ovf_a, b: ovf_b};

    // Counter output is registered, so ovf trails its tick by one cycle
    a_ovf_a_tick: assert property (@(posedge clk) disable iff (!rst_n)
        ovf_a |-> $past(tick_a));

endmodule

`default_nettype wire

/* hdl/fm_status_result.sv */
// Overflow flags, irq_n and the status byte
`default_nettype none

module fm_status_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fm_timer_pkg::tmr_cfg_t    cfg,
    input  fm_timer_pkg::flag_pulse_t clr,
    input  fm_timer_pkg::flag_pulse_t ovf,
    input  logic                      busy,
    output logic [7:0]                dout,
    output logic                      irq_n
);
    import fm_timer_pkg::*;

    flag_pulse_t flag;

    // Sticky flags, a new overflow beats a clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag <= '0;
        end else begin
            if (ovf.a) begin
                flag.a <= 1'b1;
            end else if (clr.a) begin
                flag.a <= 1'b0;
            end
            if (ovf.b) begin
                flag.b <= 1'b1;
            end else if (clr.b) begin
                flag.b <= 1'b0;
            end
        end
    end

    assign irq_n = !((flag.a && cfg.irq_en_a) || (flag.b && cfg.irq_en_b));

    assign dout = {busy, 5'b00000, flag.b, flag.a};   // Status byte

    a_irq_masked: assert property (@(posedge clk) disable iff (!rst_n)
        (!cfg.irq_en_a && !cfg.irq_en_b) |-> irq_n);

endmodule

`default_nettype wire

/* hdl/fm_timer_top.sv */
// Timer and status top level joining decode, execute and result stages
`default_nettype none

module fm_timer_top #(
    parameter int tick_div    = 72,   // cen pulses per timer A tick
    parameter int busy_cycles = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);
    import fm_timer_pkg::*;

    tmr_cfg_t    cfg;
    flag_pulse_t clr;
    flag_pulse_t ovf;
    logic        busy;

    fm_reg_decode #(.busy_cycles(busy_cycles)) u_decode (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .cfg   ( cfg   ),
        .clr   ( clr   ),
        .busy  ( busy  )
    );

    fm_timer_exec #(.tick_div(tick_div)) u_exec (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cen   ( cen   ),
        .cfg   ( cfg   ),
        .ovf   ( ovf   )
    );

    fm_status_result u_result (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cfg   ( cfg   ),
        .clr   ( clr   ),
        .ovf   ( ovf   ),
        .busy  ( busy  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

endmodule

`default_nettype wire

/* bench/fm_timer_tb.sv */
// Testbench for the timer top level, runs the stim command file and checks dout and irq_n
`default_nettype none

module fm_timer_tb;

    localparam int tick_div    = 4;
    localparam int busy_cycles = 8;
    localparam int max_cmds    = 128;

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    logic [7:0] cmd_op [max_cmds];   // Command letter
    int         cmd_a  [max_cmds];
    int         cmd_b  [max_cmds];
    int         cmd_c  [max_cmds];
    int         num_cmds      = 0;
    int         checks        = 0;
    int         value_errors  = 0;
    int         timing_errors = 0;
    int         stim_errors   = 0;
    int         cycle_cnt     = 0;
    int         cycle_limit   = 1000000;   // Replaced once the stim file is read

    fm_timer_top #(
        .tick_div    ( tick_div    ),
        .busy_cycles ( busy_cycles )
    ) fm_timer_top_inst (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cen   ( cen   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog on the total cycle count
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Run stopped after %0d cycles, the commands did not finish in time",
                     cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic read_stim();
        int         fd;
        string      line;
        logic [7:0] op;
        int         a;
        int         b;
        int         c;
        fd = $fopen("bench/fm_timer_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stim file bench/fm_timer_stim.txt");
            stim_errors++;
            return;
        end
        cycle_limit = 200;
        while (!$feof(fd)) begin
            line = "";
            op   = "\n";
            a    = 0;
            b    = 0;
            c    = 0;
            void'($fgets(line, fd));
            void'($sscanf(line, "%c %h %h %h", op, a, b, c));
            case (op)
                "W", "S", "I", "F", "N": begin
                    cmd_op[num_cmds] = op;
                    cmd_a[num_cmds]  = a;
                    cmd_b[num_cmds]  = b;
                    cmd_c[num_cmds]  = c;
                    num_cmds++;
                    if (op == "W") cycle_limit += 20;
                    if (op == "N") cycle_limit += a;
                    if (op == "F") cycle_limit += c;
                end
                "#", "\n", "\r", " ": ;   // Comment or blank line
                default: begin
                    $display("Unknown command in stim file: %s", line);
                    stim_errors++;
                end
            endcase
        end
        $fclose(fd);
    endtask

    // Register number at address 0 and then data at address 1, one cycle each
    task automatic write_reg(input logic [7:0] num, input logic [7:0] data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'd0;
        din  = num;
        @(negedge clk);
        addr = 2'd1;
        din  = data;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'd0;
        din  = 8'h00;
    endtask

    task automatic check_status(input logic [7:0] exp);
        checks++;
        if (dout !== exp) begin
            $display("error at %0t: dout expected %02h, got %02h", $time, exp, dout);
            value_errors++;
        end
    endtask

    task automatic check_irq(input logic exp);
        checks++;
        if (irq_n !== exp) begin
            $display("error at %0t: irq_n expected %0b, got %0b", $time, exp, irq_n);
            value_errors++;
        end
    endtask

    task automatic wait_flag(input logic [7:0] mask, input int min_cyc, input int max_cyc);
        int waited;
        waited = 0;
        while ((dout & mask) == 8'h00 && waited < max_cyc) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if ((dout & mask) == 8'h00) begin
            $display("At %0t the flag for mask %02h was still clear after %0d cycles",
                     $time, mask, max_cyc);
            timing_errors++;
        end else if (waited < min_cyc) begin
            $display("At %0t the flag for mask %02h rose early, after %0d of %0d cycles",
                     $time, mask, waited, min_cyc);
            timing_errors++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        cen   = 1'b1;
        din   = 8'h00;
        addr  = 2'd0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        read_stim();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < num_cmds; i++) begin
            case (cmd_op[i])
                "W": write_reg(cmd_a[i][7:0], cmd_b[i][7:0]);
                "S": check_status(cmd_a[i][7:0]);
                "I": check_irq(cmd_a[i][0]);
                "F": wait_flag(cmd_a[i][7:0], cmd_b[i], cmd_c[i]);
                "N": repeat (cmd_a[i]) @(negedge clk);
                default: ;
            endcase
        end
        $display("checks %0d, value errors %0d, timing errors %0d, stim errors %0d",
                 checks, value_errors, timing_errors, stim_errors);
        if (value_errors + timing_errors + stim_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/fm_timer_stim.txt */
# W reg data | S expected dout | I expected irq_n | N idle cycles
# F mask min max waits for a status flag, all operands hex, F limits in cycles
S 00
I 1
# busy window, then restarted by a second data write
W 26 00
S 80
N 5
S 80
W 26 00
S 80
N 6
S 80
N 2
S 00
# timer A at 0x3F0 gives 16 ticks of 4 cycles
W 24 FC
W 25 00
W 27 01
F 01 3C 44
S 01
I 1
N 28
S 01
W 27 05
I 0
W 27 14
N 1
I 1
N 8
S 00
# timer B at 0xFE gives 2 ticks of 64 cycles
W 26 FE
W 27 02
F 03 40 C0
S 02
W 27 20
N 9
S 00
# both loads off, no flag over a long idle wait
N C8
S 00
I 1

/* fm_timer.f */
hdl/fm_timer_pkg.sv
hdl/fm_timer_counter.sv
hdl/fm_reg_decode.sv
hdl/fm_timer_exec.sv
hdl/fm_status_result.sv
hdl/fm_timer_top.sv
bench/fm_timer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the timer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
fail_msg='*** TEST FAILED ***'

if ! verilator --binary --timing --assert -Wno-fatal --top-module fm_timer_tb \
        -f fm_timer.f -o fm_timer_sim > "$build_log" 2>&1; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/fm_timer_sim > "$sim_log" 2>&1; then
    cat "$sim_log"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$sim_log"

if grep -qF "$fail_msg" "$sim_log"; then
    echo "Result: fail"
    exit 1
fi
echo "Result: pass"
exit 0
